// File: logic/decodePkg.sv
// Decode stage shared definitions
// Holds the instruction field positions, the opcode values, the functional
// unit and access size encodings and the result buffer states
package decodePkg;

	// ================================================
	// Instruction format
	// ================================================

	// Field widths
	localparam int opcodeBits = 7;
	localparam int regBits = 6;
	localparam int immBits = 13;
	// Sign copies needed to widen the immediate to a full word
	localparam int immExtBits = 32 - immBits;

	// Lowest bit of each field in the instruction word
	localparam int opcodeLsb = 0;
	localparam int rdLsb = 7;
	localparam int rs1Lsb = 13;
	localparam int rs2Lsb = 19;
	// The immediate shares its low bits with source two, bit 31 is the sign
	localparam int immLsb = 19;

	typedef logic [31:0] instrWord;
	typedef logic [opcodeBits-1:0] opcodeField;
	typedef logic [regBits-1:0] regNum;
	typedef logic [31:0] immWord;

	// ================================================
	// Opcodes
	// ================================================

	// Register forms
	localparam opcodeField OP_ADD = 7'h02;
	localparam opcodeField OP_SUB = 7'h03;
	localparam opcodeField OP_AND = 7'h04;
	localparam opcodeField OP_OR = 7'h05;
	localparam opcodeField OP_MUL = 7'h06;
	localparam opcodeField OP_DIV = 7'h07;
	// Immediate arithmetic
	localparam opcodeField OP_ADDI = 7'h10;
	localparam opcodeField OP_CMPI = 7'h11;
	localparam opcodeField OP_MULI = 7'h12;
	localparam opcodeField OP_DIVI = 7'h13;
	localparam opcodeField OP_ANDI = 7'h14;
	localparam opcodeField OP_ORI = 7'h15;
	localparam opcodeField OP_EORI = 7'h16;
	localparam opcodeField OP_SLTI = 7'h17;
	// Flow control
	localparam opcodeField OP_JSR = 7'h20;
	localparam opcodeField OP_RTD = 7'h21;
	localparam opcodeField OP_BEQ = 7'h22;
	// Loads, the letter gives the access size
	localparam opcodeField OP_LDB = 7'h40;
	localparam opcodeField OP_LDW = 7'h41;
	localparam opcodeField OP_LDT = 7'h42;
	localparam opcodeField OP_LDO = 7'h43;
	// Stores
	localparam opcodeField OP_STB = 7'h50;
	localparam opcodeField OP_STW = 7'h51;
	localparam opcodeField OP_STT = 7'h52;
	localparam opcodeField OP_STO = 7'h53;
	localparam opcodeField OP_NOP = 7'h7F;

	// Functional unit that executes the instruction
	typedef enum logic [2:0] {UNIT_ALU, UNIT_MULDIV, UNIT_LOAD, UNIT_STORE, UNIT_BRANCH} execUnit;

	// Memory access size for loads and stores
	typedef enum logic [1:0] {SIZE_BYTE, SIZE_WYDE, SIZE_TETRA, SIZE_OCTA} memSize;

	// Occupancy of the two-entry result buffer
	typedef enum logic [1:0] {BUF_EMPTY, BUF_ONE, BUF_TWO} bufState;

endpackage

// File: logic/immDecode.sv
// Immediate decoder
// Flags the opcodes that carry an immediate and sign-extends the 13-bit
// immediate field to a full word
`timescale 1ns/100ps

module immDecode
(
	input decodePkg::instrWord instr,
	output logic hasImm,
	output decodePkg::immWord imm
);

	decodePkg::opcodeField opcode;
	logic [decodePkg::immBits-1:0] immField;

	assign opcode = instr[decodePkg::opcodeLsb +: decodePkg::opcodeBits];
	// The field runs from immLsb up to the sign bit at the top of the word
	assign immField = instr[decodePkg::immLsb +: decodePkg::immBits];

	always_comb
	begin
		case (opcode)
			// Immediate arithmetic and compare
			decodePkg::OP_ADDI, decodePkg::OP_CMPI, decodePkg::OP_MULI, decodePkg::OP_DIVI,
			decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI, decodePkg::OP_SLTI:
				hasImm = 1'b1;
			// Branch targets and displacements
			decodePkg::OP_JSR, decodePkg::OP_RTD, decodePkg::OP_BEQ:
				hasImm = 1'b1;
			// Address offsets for loads and stores
			decodePkg::OP_LDB, decodePkg::OP_LDW, decodePkg::OP_LDT, decodePkg::OP_LDO,
			decodePkg::OP_STB, decodePkg::OP_STW, decodePkg::OP_STT, decodePkg::OP_STO:
				hasImm = 1'b1;
			// Register forms, the no-op and anything not recognised
			default:
				hasImm = 1'b0;
		endcase
	end

	// Issue only looks at imm when hasImm is set, but a clean zero keeps
	// the buffered payload easy to compare
	always_comb
	begin
		if (hasImm)
		begin
			imm = {{decodePkg::immExtBits{immField[decodePkg::immBits-1]}}, immField};
		end
		else
		begin
			imm = '0;
		end
	end

endmodule

// File: logic/regFieldDecode.sv
// Register field decoder
// Pulls the destination and source register numbers out of the word and
// decides whether the destination is written back
`timescale 1ns/100ps

module regFieldDecode
(
	input decodePkg::instrWord instr,
	output decodePkg::regNum rd,
	output decodePkg::regNum rs1,
	output decodePkg::regNum rs2,
	output logic regWrite
);

	decodePkg::opcodeField opcode;
	decodePkg::regNum rs2Field;
	// Set when the source two bits belong to an immediate
	logic zeroRs2;
	// Set when the opcode produces a result for the destination
	logic writesRd;

	assign opcode = instr[decodePkg::opcodeLsb +: decodePkg::opcodeBits];
	assign rd = instr[decodePkg::rdLsb +: decodePkg::regBits];
	assign rs1 = instr[decodePkg::rs1Lsb +: decodePkg::regBits];
	assign rs2Field = instr[decodePkg::rs2Lsb +: decodePkg::regBits];

	always_comb
	begin
		case (opcode)
			// Register forms read both sources and write the destination
			decodePkg::OP_ADD, decodePkg::OP_SUB, decodePkg::OP_AND, decodePkg::OP_OR,
			decodePkg::OP_MUL, decodePkg::OP_DIV:
			begin
				writesRd = 1'b1;
				zeroRs2 = 1'b0;
			end
			// Immediate forms, subroutine calls, returns and loads write a result
			decodePkg::OP_ADDI, decodePkg::OP_CMPI, decodePkg::OP_MULI, decodePkg::OP_DIVI,
			decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI, decodePkg::OP_SLTI,
			decodePkg::OP_JSR, decodePkg::OP_RTD,
			decodePkg::OP_LDB, decodePkg::OP_LDW, decodePkg::OP_LDT, decodePkg::OP_LDO:
			begin
				writesRd = 1'b1;
				zeroRs2 = 1'b1;
			end
			// Conditional branch and stores carry an immediate but write nothing
			decodePkg::OP_BEQ,
			decodePkg::OP_STB, decodePkg::OP_STW, decodePkg::OP_STT, decodePkg::OP_STO:
			begin
				writesRd = 1'b0;
				zeroRs2 = 1'b1;
			end
			// No-op and unknown opcodes leave the register file alone
			default:
			begin
				writesRd = 1'b0;
				zeroRs2 = 1'b0;
			end
		endcase
	end

	assign rs2 = zeroRs2 ? '0 : rs2Field;
	// Register 0 is hardwired, so a write to it is dropped here
	assign regWrite = writesRd && (rd != '0);

endmodule

// File: logic/unitSelect.sv
// Functional unit selector
// Routes each opcode to the unit that executes it and gives the memory
// access size for loads and stores
`timescale 1ns/100ps

module unitSelect
(
	input decodePkg::instrWord instr,
	output decodePkg::execUnit unit,
	output decodePkg::memSize size
);

	decodePkg::opcodeField opcode;

	assign opcode = instr[decodePkg::opcodeLsb +: decodePkg::opcodeBits];

	always_comb
	begin
		// Anything not listed is plain ALU work at full width
		unit = decodePkg::UNIT_ALU;
		size = decodePkg::SIZE_OCTA;
		case (opcode)
			// Multiplier and divider share one unit
			decodePkg::OP_MUL, decodePkg::OP_DIV, decodePkg::OP_MULI, decodePkg::OP_DIVI:
				unit = decodePkg::UNIT_MULDIV;
			decodePkg::OP_JSR, decodePkg::OP_RTD, decodePkg::OP_BEQ:
				unit = decodePkg::UNIT_BRANCH;
			// Loads, by size letter
			decodePkg::OP_LDB:
			begin
				unit = decodePkg::UNIT_LOAD;
				size = decodePkg::SIZE_BYTE;
			end
			decodePkg::OP_LDW:
			begin
				unit = decodePkg::UNIT_LOAD;
				size = decodePkg::SIZE_WYDE;
			end
			decodePkg::OP_LDT:
			begin
				unit = decodePkg::UNIT_LOAD;
				size = decodePkg::SIZE_TETRA;
			end
			decodePkg::OP_LDO:
				unit = decodePkg::UNIT_LOAD;
			// Stores, by size letter
			decodePkg::OP_STB:
			begin
				unit = decodePkg::UNIT_STORE;
				size = decodePkg::SIZE_BYTE;
			end
			decodePkg::OP_STW:
			begin
				unit = decodePkg::UNIT_STORE;
				size = decodePkg::SIZE_WYDE;
			end
			decodePkg::OP_STT:
			begin
				unit = decodePkg::UNIT_STORE;
				size = decodePkg::SIZE_TETRA;
			end
			decodePkg::OP_STO:
				unit = decodePkg::UNIT_STORE;
			default:
				unit = decodePkg::UNIT_ALU;
		endcase
	end

endmodule

// File: logic/decodeControl.sv
// Decode result buffer
// Two-entry buffer between fetch and issue. The head entry drives the
// outputs and the spare entry absorbs one result of back-pressure, so
// inReady can come straight from a flop
`timescale 1ns/100ps

module decodeControl
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input logic outReady,
	output logic outValid,
	input logic hasImm,
	input decodePkg::immWord imm,
	input decodePkg::regNum rd,
	input decodePkg::regNum rs1,
	input decodePkg::regNum rs2,
	input logic regWrite,
	input decodePkg::execUnit unit,
	input decodePkg::memSize size,
	output logic outHasImm,
	output decodePkg::immWord outImm,
	output decodePkg::regNum outRd,
	output decodePkg::regNum outRs1,
	output decodePkg::regNum outRs2,
	output logic outRegWrite,
	output decodePkg::execUnit outUnit,
	output decodePkg::memSize outSize
);

	decodePkg::bufState state;
	decodePkg::bufState stateNext;
	logic accept;
	logic deliver;
	// Head is loaded from the decoders or from the spare, never both
	logic loadHeadIn;
	logic loadHeadSpare;
	logic loadSpare;

	// Spare entry payload
	logic spareHasImm;
	decodePkg::immWord spareImm;
	decodePkg::regNum spareRd;
	decodePkg::regNum spareRs1;
	decodePkg::regNum spareRs2;
	logic spareRegWrite;
	decodePkg::execUnit spareUnit;
	decodePkg::memSize spareSize;

	assign accept = inValid && inReady;
	assign deliver = outValid && outReady;

	// ================================================
	// Buffer state machine
	// ================================================

	always_comb
	begin
		stateNext = state;
		loadHeadIn = 1'b0;
		loadHeadSpare = 1'b0;
		loadSpare = 1'b0;
		case (state)
			decodePkg::BUF_EMPTY:
				if (accept)
				begin
					stateNext = decodePkg::BUF_ONE;
					loadHeadIn = 1'b1;
				end
			decodePkg::BUF_ONE:
				// Head leaves while a new word arrives, so the new one takes its place
				if (accept && deliver)
				begin
					loadHeadIn = 1'b1;
				end
				else if (accept)
				begin
					stateNext = decodePkg::BUF_TWO;
					loadSpare = 1'b1;
				end
				else if (deliver)
				begin
					stateNext = decodePkg::BUF_EMPTY;
				end
			decodePkg::BUF_TWO:
				// The older spare result moves up to keep acceptance order
				if (deliver)
				begin
					stateNext = decodePkg::BUF_ONE;
					loadHeadSpare = 1'b1;
				end
			default:
				stateNext = decodePkg::BUF_EMPTY;
		endcase
	end

	// Both handshake outputs are registered from the next state
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= decodePkg::BUF_EMPTY;
			inReady <= 1'b1;
			outValid <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			inReady <= (stateNext != decodePkg::BUF_TWO);
			outValid <= (stateNext != decodePkg::BUF_EMPTY);
		end
	end

	// ================================================
	// Payload registers
	// ================================================

	always_ff @(posedge clk)
	begin
		if (loadHeadIn)
		begin
			outHasImm <= hasImm;
			outImm <= imm;
			outRd <= rd;
			outRs1 <= rs1;
			outRs2 <= rs2;
			outRegWrite <= regWrite;
			outUnit <= unit;
			outSize <= size;
		end
		else if (loadHeadSpare)
		begin
			outHasImm <= spareHasImm;
			outImm <= spareImm;
			outRd <= spareRd;
			outRs1 <= spareRs1;
			outRs2 <= spareRs2;
			outRegWrite <= spareRegWrite;
			outUnit <= spareUnit;
			outSize <= spareSize;
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadSpare)
		begin
			spareHasImm <= hasImm;
			spareImm <= imm;
			spareRd <= rd;
			spareRs1 <= rs1;
			spareRs2 <= rs2;
			spareRegWrite <= regWrite;
			spareUnit <= unit;
			spareSize <= size;
		end
	end

	// Fetch is held off only after a second word arrives while the head waits for issue
	assert property (@(posedge clk) disable iff (!arstN)
		$fell(inReady) |-> $past(outValid && accept && !deliver));

	// A stalled result must not change under issue
	assert property (@(posedge clk) disable iff (!arstN)
		(outValid && !outReady) |=> (outValid && $stable(outHasImm) && $stable(outImm)
		&& $stable(outRd) && $stable(outRs1) && $stable(outRs2) && $stable(outRegWrite)
		&& $stable(outUnit) && $stable(outSize)));

endmodule

// File: logic/decodeStage.sv
// Instruction decode stage
// Decodes each word offered by fetch into immediate, register and unit
// fields and buffers the result for issue
`timescale 1ns/100ps

module decodeStage
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input decodePkg::instrWord inInstr,
	output logic inReady,
	output logic outValid,
	input logic outReady,
	output logic outHasImm,
	output decodePkg::immWord outImm,
	output decodePkg::regNum outRd,
	output decodePkg::regNum outRs1,
	output decodePkg::regNum outRs2,
	output logic outRegWrite,
	output decodePkg::execUnit outUnit,
	output decodePkg::memSize outSize
);

	// Combinational decode of the word on the fetch side
	logic hasImm;
	decodePkg::immWord imm;
	decodePkg::regNum rd;
	decodePkg::regNum rs1;
	decodePkg::regNum rs2;
	logic regWrite;
	decodePkg::execUnit unit;
	decodePkg::memSize size;

	immDecode uImmDecode
	(
		.instr(inInstr),
		.hasImm(hasImm),
		.imm(imm)
	);

	regFieldDecode uRegFieldDecode
	(
		.instr(inInstr),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.regWrite(regWrite)
	);

	unitSelect uUnitSelect
	(
		.instr(inInstr),
		.unit(unit),
		.size(size)
	);

	// Captures the decoded fields on acceptance and hands them to issue
	decodeControl uDecodeControl
	(
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.outReady(outReady),
		.outValid(outValid),
		.hasImm(hasImm),
		.imm(imm),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.regWrite(regWrite),
		.unit(unit),
		.size(size),
		.outHasImm(outHasImm),
		.outImm(outImm),
		.outRd(outRd),
		.outRs1(outRs1),
		.outRs2(outRs2),
		.outRegWrite(outRegWrite),
		.outUnit(outUnit),
		.outSize(outSize)
	);

endmodule

// File: dv/tb_decodeStage.sv
// Testbench for the instruction decode stage
// Offers the words from the pattern file to fetch side, first back to back
// with issue always ready, then again with random idle gaps and random
// back-pressure, and checks every delivered result and both handshakes
`timescale 1ns/100ps

module tb_decodeStage;

	localparam int numPatterns = 20;
	// Instruction word followed by the eight expected fields
	localparam int wordsPerPattern = 9;
	localparam int timeoutCycles = 200;

	logic clk;
	logic arstN;
	logic inValid;
	decodePkg::instrWord inInstr;
	logic inReady;
	logic outValid;
	logic outReady;
	logic outHasImm;
	decodePkg::immWord outImm;
	decodePkg::regNum outRd;
	decodePkg::regNum outRs1;
	decodePkg::regNum outRs2;
	logic outRegWrite;
	decodePkg::execUnit outUnit;
	decodePkg::memSize outSize;

	logic [31:0] patMem [0:numPatterns*wordsPerPattern-1];
	logic [31:0] rngState;
	// Random outReady is only applied in the second pass
	logic stallOn;
	logic monitorOn;
	logic fullSeen;
	int cycleCount = 0;
	int acceptedCount;
	int deliveredCount;
	// The latency check compares delivery cycles with these acceptance cycles
	int acceptCycle [0:2*numPatterns-1];

	decodeStage uut
	(
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.outValid(outValid),
		.outReady(outReady),
		.outHasImm(outHasImm),
		.outImm(outImm),
		.outRd(outRd),
		.outRs1(outRs1),
		.outRs2(outRs2),
		.outRegWrite(outRegWrite),
		.outUnit(outUnit),
		.outSize(outSize)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	// ================================================
	// Helpers
	// ================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Marks memory words that the pattern file never wrote
	function automatic logic [31:0] fillWord(input int addr);
		return 32'hA5C3_0000 | 32'(addr);
	endfunction

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("ERROR at %0t ns: %s expected %0b, actual %0b",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkImm(input string name, input decodePkg::immWord expected,
		input decodePkg::immWord actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("ERROR at %0t ns: %s expected %h, actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkReg(input string name, input decodePkg::regNum expected,
		input decodePkg::regNum actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("ERROR at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkUnit(input string name, input decodePkg::execUnit expected,
		input decodePkg::execUnit actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("ERROR at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkSize(input string name, input decodePkg::memSize expected,
		input decodePkg::memSize actual);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("ERROR at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual));
		end
	endtask

	// Compares the result on the issue side with one line of the pattern file
	task automatic checkResult(input int idx);
		int base;
		string tag;
		base = idx * wordsPerPattern;
		tag = $sformatf(" of pattern %0d", idx);
		checkBit({"outHasImm", tag}, patMem[base + 1][0], outHasImm);
		checkImm({"outImm", tag}, patMem[base + 2], outImm);
		checkReg({"outRd", tag}, patMem[base + 3][5:0], outRd);
		checkReg({"outRs1", tag}, patMem[base + 4][5:0], outRs1);
		checkReg({"outRs2", tag}, patMem[base + 5][5:0], outRs2);
		checkBit({"outRegWrite", tag}, patMem[base + 6][0], outRegWrite);
		checkUnit({"outUnit", tag}, decodePkg::execUnit'(patMem[base + 7][2:0]), outUnit);
		checkSize({"outSize", tag}, decodePkg::memSize'(patMem[base + 8][1:0]), outSize);
	endtask

	// Advances to just after the next rising edge and redraws outReady when stalls are on
	task automatic nextCycle();
		@(posedge clk);
		#1;
		if (stallOn)
		begin
			rngState = xorshift32(rngState);
			outReady = rngState[0];
		end
	endtask

	// Offers one word to the DUT and returns once it has been taken
	task automatic offerWord(input int idx, input logic allowGap);
		int gap;
		int waited;
		logic taken;
		if (allowGap)
		begin
			rngState = xorshift32(rngState);
			// Roughly one word in four is preceded by a short idle stretch
			if (rngState[5:4] == 2'b00)
			begin
				inValid = 1'b0;
				gap = rngState[7:6] + 1;
				repeat (gap) nextCycle();
			end
		end
		inValid = 1'b1;
		inInstr = patMem[idx * wordsPerPattern];
		taken = 1'b0;
		waited = 0;
		while (!taken)
		begin
			@(negedge clk);
			taken = inReady;
			nextCycle();
			waited = waited + 1;
			if (!taken && waited >= timeoutCycles)
			begin
				stopWithFailure($sformatf(
					"Timed out after %0d cycles waiting for word %0d to be accepted",
					timeoutCycles, idx));
			end
		end
	endtask

	// Waits until the given number of results has left the stage
	task automatic drainResults(input int target);
		int waited;
		waited = 0;
		while (deliveredCount < target)
		begin
			if (waited >= timeoutCycles)
			begin
				stopWithFailure($sformatf("Timed out after %0d cycles waiting for result %0d",
					timeoutCycles, deliveredCount));
			end
			nextCycle();
			waited = waited + 1;
		end
	endtask

	// ================================================
	// Monitor
	// ================================================

	// Sampling at the falling edge sees the values that the next rising
	// edge will transfer, so both handshakes are judged here
	always @(negedge clk)
	begin : watchStage
		int occupancy;
		if (monitorOn)
		begin
			occupancy = acceptedCount - deliveredCount;
			// The buffer must report exactly what has gone in and not yet out
			checkBit("outValid", occupancy > 0, outValid);
			checkBit("inReady", occupancy < 2, inReady);
			if (!inReady)
			begin
				fullSeen = 1'b1;
			end
			if (outValid && outReady)
			begin
				checkResult(deliveredCount % numPatterns);
				// First pass has no stalls, so each result shows up one cycle after its word
				if (deliveredCount < numPatterns
					&& cycleCount != acceptCycle[deliveredCount] + 1)
				begin
					stopWithFailure($sformatf(
						"Result %0d was delivered in cycle %0d instead of cycle %0d",
						deliveredCount, cycleCount, acceptCycle[deliveredCount] + 1));
				end
				deliveredCount = deliveredCount + 1;
			end
			if (inValid && inReady)
			begin
				if (acceptedCount > 0 && acceptedCount < numPatterns
					&& cycleCount != acceptCycle[acceptedCount - 1] + 1)
				begin
					stopWithFailure($sformatf(
						"Word %0d was not accepted in the cycle after the previous word",
						acceptedCount));
				end
				acceptCycle[acceptedCount] = cycleCount;
				acceptedCount = acceptedCount + 1;
			end
		end
	end

	// ================================================
	// Stimulus
	// ================================================

	initial
	begin
		clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		outReady = 1'b0;
		stallOn = 1'b0;
		monitorOn = 1'b0;
		fullSeen = 1'b0;
		rngState = 32'd6;
		acceptedCount = 0;
		deliveredCount = 0;

		for (int i = 0; i < numPatterns * wordsPerPattern; i++)
		begin
			patMem[i] = fillWord(i);
		end
		$readmemh("dv/decodePatterns.hex", patMem);
		if (patMem[numPatterns*wordsPerPattern-1] == fillWord(numPatterns*wordsPerPattern-1))
		begin
			stopWithFailure("The pattern file holds fewer patterns than expected");
		end

		repeat (2) @(posedge clk);
		#1;
		arstN = 1'b1;
		outReady = 1'b1;
		monitorOn = 1'b1;

		// Empty buffer after reset
		@(negedge clk);
		checkBit("outValid after reset", 1'b0, outValid);
		checkBit("inReady after reset", 1'b1, inReady);
		nextCycle();

		// Back to back with issue always ready
		for (int i = 0; i < numPatterns; i++)
		begin
			offerWord(i, 1'b0);
		end
		inValid = 1'b0;
		drainResults(numPatterns);

		// Same words again under random gaps and back-pressure
		stallOn = 1'b1;
		for (int i = 0; i < numPatterns; i++)
		begin
			offerWord(i, 1'b1);
		end
		inValid = 1'b0;
		drainResults(2 * numPatterns);
		stallOn = 1'b0;
		outReady = 1'b1;

		// A few quiet cycles catch any extra result
		repeat (4) nextCycle();

		if (!fullSeen)
		begin
			stopWithFailure("The buffer never filled to two entries under back-pressure");
		end
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: files.f
logic/decodePkg.sv
logic/immDecode.sv
logic/regFieldDecode.sv
logic/unitSelect.sv
logic/decodeControl.sv
logic/decodeStage.sv
dv/tb_decodeStage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_decodeStage -o simDecode

simOutput=$(./obj_dir/simDecode) || true
echo "$simOutput"

if echo "$simOutput" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// File: dv/decodePatterns.hex
// instr hasImm imm rd rs1 rs2 regWrite unit size, one pattern per line
// unit 0 alu 1 muldiv 2 load 3 store 4 branch, size 0 byte 1 wyde 2 tetra 3 octa
00386282 0 00000000 05 03 07 1 0 3
FFF84083 0 00000000 01 02 3F 1 0 3
00488007 0 00000000 00 04 09 0 1 3
0320E310 1 00000064 06 07 00 1 0 3
FFF92411 1 FFFFFFFF 08 09 00 1 0 3
8001A612 1 FFFFF000 0C 0D 00 1 1 3
7FF9E713 1 00000FFF 0E 0F 00 1 1 3
FFF02017 1 FFFFFFFE 00 01 00 0 0 3
10000FA0 1 00000200 1F 00 00 1 4 3
FFC06122 1 FFFFFFF8 02 03 00 0 4 3
0082AA40 1 00000010 14 15 00 1 2 0
FF82EB41 1 FFFFFFF0 16 17 00 1 2 1
00432C42 1 00000008 18 19 00 1 2 2
000FDFC3 1 00000001 3F 3E 00 1 2 3
FF00A250 1 FFFFFFE0 04 05 00 0 3 0
0100E351 1 00000020 06 07 00 0 3 1
00192452 1 00000003 08 09 00 0 3 2
FFE96553 1 FFFFFFFD 0A 0B 00 0 3 3
0038C2FF 0 00000000 05 06 07 0 0 3
805944B0 0 00000000 09 0A 0B 0 0 3
